// ==== build.f ====
logic/frame_pkg.sv
logic/frame_cfg_regs.sv
logic/hdr_inserter.sv
logic/frame_truncator.sv
logic/frame_path_top.sv
tb/frame_path_checker.sv
tb/frame_path_tb.sv

// ==== logic/frame_cfg_regs.sv ====
// Wishbone classic slave, single transfers only, ack one cycle after the request
// Configuration must only be changed while no frame is in flight
module frame_cfg_regs (
    input  logic                  core_clk_ifc,
    input  logic                  i_rst_n,
    input  frame_pkg::wb_req_t    i_wb_req,
    output frame_pkg::wb_rsp_t    o_wb_rsp,
    output frame_pkg::frame_cfg_t o_cfg,
    input  logic                  i_frame_done,
    input  logic                  i_frame_cut
);

    frame_pkg::frame_cfg_t cfg_q;
    frame_pkg::count_t     frame_cnt_q;
    frame_pkg::count_t     trunc_cnt_q;
    frame_pkg::wb_data_t   rd_data;
    frame_pkg::wb_data_t   rd_data_q;
    logic                  ack_q;
    logic                  req_new;

    // Request seen and not yet acknowledged
    assign req_new = i_wb_req.cyc && i_wb_req.stb && !ack_q;

    //////////////////////////////////////////////////
    // Read mux

    always_comb begin
        rd_data = '0;
        case (i_wb_req.adr)
            frame_pkg::REG_DST_MAC_HI:  rd_data = {16'h0000, cfg_q.dst_mac[47:32]};
            frame_pkg::REG_DST_MAC_LO:  rd_data = cfg_q.dst_mac[31:0];
            frame_pkg::REG_SRC_MAC_HI:  rd_data = {16'h0000, cfg_q.src_mac[47:32]};
            frame_pkg::REG_SRC_MAC_LO:  rd_data = cfg_q.src_mac[31:0];
            frame_pkg::REG_ETHERTYPE:   rd_data = {16'h0000, cfg_q.ethertype};
            frame_pkg::REG_CTRL:        rd_data = {31'h0, cfg_q.hdr_en};
            frame_pkg::REG_MAX_LEN:     rd_data = {16'h0000, cfg_q.max_len};
            frame_pkg::REG_FRAME_COUNT: rd_data = frame_cnt_q;
            frame_pkg::REG_TRUNC_COUNT: rd_data = trunc_cnt_q;
            default:                    rd_data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register writes

    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            cfg_q.dst_mac   <= frame_pkg::RST_DST_MAC;
            cfg_q.src_mac   <= frame_pkg::RST_SRC_MAC;
            cfg_q.ethertype <= frame_pkg::RST_ETHERTYPE;
            cfg_q.hdr_en    <= 1'b0;
            cfg_q.max_len   <= frame_pkg::RST_MAX_LEN;
        end else if (req_new && i_wb_req.we) begin
            case (i_wb_req.adr)
                frame_pkg::REG_DST_MAC_HI: cfg_q.dst_mac[47:32] <= i_wb_req.dat[15:0];
                frame_pkg::REG_DST_MAC_LO: cfg_q.dst_mac[31:0]  <= i_wb_req.dat;
                frame_pkg::REG_SRC_MAC_HI: cfg_q.src_mac[47:32] <= i_wb_req.dat[15:0];
                frame_pkg::REG_SRC_MAC_LO: cfg_q.src_mac[31:0]  <= i_wb_req.dat;
                frame_pkg::REG_ETHERTYPE:  cfg_q.ethertype      <= i_wb_req.dat[15:0];
                frame_pkg::REG_CTRL:       cfg_q.hdr_en         <= i_wb_req.dat[0];
                frame_pkg::REG_MAX_LEN:    cfg_q.max_len        <= i_wb_req.dat[15:0];
                // Counters and unmapped words drop the write
                default: ;
            endcase
        end
    end

    // Ack for exactly one cycle, master drops stb after it
    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (req_new) begin
            rd_data_q <= rd_data;
        end
    end

    //////////////////////////////////////////////////
    // Frame counters, wrap at full scale

    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            frame_cnt_q <= '0;
            trunc_cnt_q <= '0;
        end else begin
            if (i_frame_done) begin
                frame_cnt_q <= frame_cnt_q + 1'b1;
            end
            if (i_frame_cut) begin
                trunc_cnt_q <= trunc_cnt_q + 1'b1;
            end
        end
    end

    assign o_wb_rsp = '{ack: ack_q, dat: rd_data_q};
    assign o_cfg    = cfg_q;

endmodule

// ==== logic/frame_path_top.sv ====
// Byte stream frame path: header inserter then truncator, with Wishbone config
// Up to two bytes in flight, one per stage
module frame_path_top (
    input  logic                    core_clk_ifc,
    input  logic                    i_rst_n,
    input  frame_pkg::wb_req_t      i_wb_req,
    output frame_pkg::wb_rsp_t      o_wb_rsp,
    input  frame_pkg::stream_beat_t i_ingress_beat,
    input  logic                    i_ingress_valid,
    output logic                    o_ingress_ready,
    output frame_pkg::stream_beat_t o_egress_beat,
    output logic                    o_egress_valid,
    input  logic                    i_egress_ready
);

    frame_pkg::frame_cfg_t   cfg;
    frame_pkg::stream_beat_t ins_beat;
    logic                    ins_valid;
    logic                    ins_ready;
    logic                    frame_done;
    logic                    frame_cut;

    frame_cfg_regs u_cfg_regs (
        .core_clk_ifc (core_clk_ifc),
        .i_rst_n      (i_rst_n),
        .i_wb_req     (i_wb_req),
        .o_wb_rsp     (o_wb_rsp),
        .o_cfg        (cfg),
        .i_frame_done (frame_done),
        .i_frame_cut  (frame_cut)
    );

    hdr_inserter u_hdr_inserter (
        .core_clk_ifc (core_clk_ifc),
        .i_rst_n      (i_rst_n),
        .i_cfg        (cfg),
        .i_beat       (i_ingress_beat),
        .i_valid      (i_ingress_valid),
        .o_ready      (o_ingress_ready),
        .o_beat       (ins_beat),
        .o_valid      (ins_valid),
        .i_ready      (ins_ready)
    );

    // Length cap applies after the header is in place
    frame_truncator u_truncator (
        .core_clk_ifc (core_clk_ifc),
        .i_rst_n      (i_rst_n),
        .i_max_len    (cfg.max_len),
        .i_beat       (ins_beat),
        .i_valid      (ins_valid),
        .o_ready      (ins_ready),
        .o_beat       (o_egress_beat),
        .o_valid      (o_egress_valid),
        .i_ready      (i_egress_ready),
        .o_frame_done (frame_done),
        .o_frame_cut  (frame_cut)
    );

endmodule

// ==== logic/frame_pkg.sv ====
// Shared widths, bus structs, register map and reset values of the frame path
// Register addresses are 32-bit word addresses on the Wishbone port
package frame_pkg;

    //////////////////////////////////////////////////
    // Width types

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [31:0] count_t;
    typedef logic [3:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    //////////////////////////////////////////////////
    // Structs

    typedef struct packed {
        byte_t data;
        logic  last;
    } stream_beat_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef struct packed {
        mac_t       dst_mac;
        mac_t       src_mac;
        ethertype_t ethertype;
        logic       hdr_en;
        frame_len_t max_len;
    } frame_cfg_t;

    //////////////////////////////////////////////////
    // Constants and register map

    localparam int HDR_BYTES = 14;

    localparam wb_addr_t REG_DST_MAC_HI  = 4'd0;
    localparam wb_addr_t REG_DST_MAC_LO  = 4'd1;
    localparam wb_addr_t REG_SRC_MAC_HI  = 4'd2;
    localparam wb_addr_t REG_SRC_MAC_LO  = 4'd3;
    localparam wb_addr_t REG_ETHERTYPE   = 4'd4;
    localparam wb_addr_t REG_CTRL        = 4'd5;
    localparam wb_addr_t REG_MAX_LEN     = 4'd6;
    localparam wb_addr_t REG_FRAME_COUNT = 4'd7;
    localparam wb_addr_t REG_TRUNC_COUNT = 4'd8;

    localparam mac_t       RST_DST_MAC   = 48'h11_22_33_44_55_66;
    localparam mac_t       RST_SRC_MAC   = 48'hAA_BB_CC_DD_EE_FF;
    localparam ethertype_t RST_ETHERTYPE = 16'h0000;
    localparam frame_len_t RST_MAX_LEN   = 16'd100;

    // FSM states
    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD} ins_state_e;
    typedef enum logic {PASS, DISCARD} trunc_state_e;

endpackage

// ==== logic/frame_truncator.sv ====
// Cuts frames to max_len bytes, header included; max_len of 0 acts as 1
// Done and cut pulse on the egress last transfer
module frame_truncator (
    input  logic                    core_clk_ifc,
    input  logic                    i_rst_n,
    input  frame_pkg::frame_len_t   i_max_len,
    input  frame_pkg::stream_beat_t i_beat,
    input  logic                    i_valid,
    output logic                    o_ready,
    output frame_pkg::stream_beat_t o_beat,
    output logic                    o_valid,
    input  logic                    i_ready,
    output logic                    o_frame_done,
    output logic                    o_frame_cut
);

    frame_pkg::trunc_state_e state_q;
    frame_pkg::frame_len_t   cnt_q;
    frame_pkg::frame_len_t   limit;
    frame_pkg::stream_beat_t beat_q;
    logic                    valid_q;
    logic                    cut_q;
    logic                    out_free;
    logic                    take_in;
    logic                    at_limit;
    logic                    cut_now;

    assign limit    = (i_max_len == '0) ? frame_pkg::frame_len_t'(1) : i_max_len;
    assign out_free = !valid_q || i_ready;
    // Discarded bytes are sunk without touching the output register
    assign o_ready  = (state_q == frame_pkg::DISCARD) || out_free;
    assign take_in  = i_valid && o_ready;
    // cnt_q holds the bytes already passed in this frame
    assign at_limit = (cnt_q >= limit - 1'b1);
    assign cut_now  = at_limit && !i_beat.last;

    //////////////////////////////////////////////////
    // FSM and byte count

    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            state_q <= frame_pkg::PASS;
            cnt_q   <= '0;
        end else if (take_in) begin
            if (state_q == frame_pkg::PASS) begin
                cnt_q <= (i_beat.last || at_limit) ? '0 : cnt_q + 1'b1;
                if (cut_now) begin
                    state_q <= frame_pkg::DISCARD;
                end
            end else if (i_beat.last) begin
                state_q <= frame_pkg::PASS;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (take_in && (state_q == frame_pkg::PASS)) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (take_in && (state_q == frame_pkg::PASS)) begin
            beat_q <= '{data: i_beat.data, last: i_beat.last || at_limit};
            cut_q  <= cut_now;
        end
    end

    assign o_beat       = beat_q;
    assign o_valid      = valid_q;
    assign o_frame_done = valid_q && i_ready && beat_q.last;
    assign o_frame_cut  = o_frame_done && cut_q;

endmodule

// ==== logic/hdr_inserter.sv ====
// Prepends the 14-byte Ethernet header from the config when hdr_en is set
// Ingress is stalled for 14 cycles per frame while the header goes out
module hdr_inserter (
    input  logic                    core_clk_ifc,
    input  logic                    i_rst_n,
    input  frame_pkg::frame_cfg_t   i_cfg,
    input  frame_pkg::stream_beat_t i_beat,
    input  logic                    i_valid,
    output logic                    o_ready,
    output frame_pkg::stream_beat_t o_beat,
    output logic                    o_valid,
    input  logic                    i_ready
);

    frame_pkg::ins_state_e             state_q;
    logic [3:0]                        hdr_idx_q;
    logic [8*frame_pkg::HDR_BYTES-1:0] hdr_bytes;
    frame_pkg::byte_t                  hdr_byte;
    frame_pkg::stream_beat_t           beat_q;
    logic                              valid_q;
    logic                              out_free;
    logic                              start_hdr;
    logic                              emit_hdr;
    logic                              take_in;

    // Header in wire order, dst MAC first, MSB first
    assign hdr_bytes = {i_cfg.dst_mac, i_cfg.src_mac, i_cfg.ethertype};
    assign hdr_byte  = hdr_bytes[8*(frame_pkg::HDR_BYTES-1-int'(hdr_idx_q)) +: 8];

    //////////////////////////////////////////////////
    // Handshake

    assign out_free  = !valid_q || i_ready;
    // Header byte 0 goes out in the same cycle the frame is spotted
    assign start_hdr = (state_q == frame_pkg::IDLE) && i_cfg.hdr_en && i_valid && out_free;
    assign emit_hdr  = start_hdr || ((state_q == frame_pkg::HEADER) && out_free);
    assign o_ready   = out_free && ((state_q == frame_pkg::PAYLOAD) ||
                                    ((state_q == frame_pkg::IDLE) && !i_cfg.hdr_en));
    assign take_in   = i_valid && o_ready;

    //////////////////////////////////////////////////
    // FSM

    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            state_q   <= frame_pkg::IDLE;
            hdr_idx_q <= '0;
        end else begin
            case (state_q)
                frame_pkg::IDLE: begin
                    if (start_hdr) begin
                        state_q   <= frame_pkg::HEADER;
                        hdr_idx_q <= 4'd1;
                    end else if (take_in && !i_beat.last) begin
                        state_q <= frame_pkg::PAYLOAD;
                    end
                end
                frame_pkg::HEADER: begin
                    if (out_free) begin
                        if (hdr_idx_q == 4'(frame_pkg::HDR_BYTES - 1)) begin
                            state_q   <= frame_pkg::PAYLOAD;
                            hdr_idx_q <= '0;
                        end else begin
                            hdr_idx_q <= hdr_idx_q + 1'b1;
                        end
                    end
                end
                frame_pkg::PAYLOAD: begin
                    if (take_in && i_beat.last) begin
                        state_q <= frame_pkg::IDLE;
                    end
                end
                default: state_q <= frame_pkg::IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (emit_hdr || take_in) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (emit_hdr) begin
            beat_q <= '{data: hdr_byte, last: 1'b0};
        end else if (take_in) begin
            beat_q <= i_beat;
        end
    end

    assign o_beat  = beat_q;
    assign o_valid = valid_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the frame path testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module frame_path_tb -f build.f -o Vframe_path_tb

status=0
./obj_dir/Vframe_path_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if [ "$status" -eq 0 ] && grep -qx "STATUS: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== tb/frame_path_checker.sv ====
// Stream, Wishbone ack and frame counter checks, bound into frame_path_top
// Checks are idle while reset is low
module frame_path_checker (
    input logic                    core_clk_ifc,
    input logic                    i_rst_n,
    input frame_pkg::wb_rsp_t      i_wb_rsp,
    input frame_pkg::stream_beat_t i_egress_beat,
    input logic                    i_egress_valid,
    input logic                    i_egress_ready,
    input frame_pkg::count_t       i_frame_count
);
    timeunit 1ns;
    timeprecision 1ns;

    logic last_xfer;

    // Last byte of a frame leaves this cycle
    assign last_xfer = i_egress_valid && i_egress_ready && i_egress_beat.last;

    // A stalled beat must hold
    a_egress_stable: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        (i_egress_valid && !i_egress_ready) |=> (i_egress_valid && $stable(i_egress_beat)))
        else $error("Egress beat dropped or changed while stalled");

    a_ack_single: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        i_wb_rsp.ack |=> !i_wb_rsp.ack)
        else $error("Wishbone ack lasted longer than one cycle");

    // The frame counter steps once per egress last transfer and at no other time
    a_count_on_last: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        last_xfer |=> (i_frame_count == $past(i_frame_count) + 1'b1))
        else $error("Frame counter did not step on an egress last transfer");

    a_count_hold: assert property (@(posedge core_clk_ifc) disable iff (!i_rst_n)
        !last_xfer |=> $stable(i_frame_count))
        else $error("Frame counter stepped without an egress last transfer");

endmodule

bind frame_path_top frame_path_checker u_checker (
    .core_clk_ifc   (core_clk_ifc),
    .i_rst_n        (i_rst_n),
    .i_wb_rsp       (o_wb_rsp),
    .i_egress_beat  (o_egress_beat),
    .i_egress_valid (o_egress_valid),
    .i_egress_ready (i_egress_ready),
    .i_frame_count  (u_cfg_regs.frame_cnt_q)
);

// ==== tb/frame_path_tb.sv ====
// Self-checking testbench for frame_path_top, needs a simulator with timing support
// Config is only changed after the egress stream has drained
module frame_path_tb;
    timeunit 1ns;
    timeprecision 1ns;

    // 48 frames of at most 104 bytes, a quarter of them under random stalls, plus register traffic
    localparam int TIMEOUT_CYCLES = 20000;

    logic                    core_clk_ifc;
    logic                    i_rst_n;
    frame_pkg::wb_req_t      wb_req;
    frame_pkg::wb_rsp_t      wb_rsp;
    frame_pkg::stream_beat_t ingress_beat;
    logic                    ingress_valid;
    logic                    ingress_ready;
    frame_pkg::stream_beat_t egress_beat;
    logic                    egress_valid;
    logic                    egress_ready;

    logic [31:0]           lfsr_q;
    logic [31:0]           ready_lfsr_q;
    logic                  rand_ready;
    frame_pkg::byte_t      payload_q[$];
    frame_pkg::byte_t      exp_data_q[$];
    logic                  exp_last_q[$];
    frame_pkg::mac_t       cfg_dst;
    frame_pkg::mac_t       cfg_src;
    frame_pkg::ethertype_t cfg_etype;
    logic                  cfg_hdr_en;
    frame_pkg::frame_len_t cfg_max_len;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    frames_total = 0;
    int                    cut_total = 0;
    int                    cycle_cnt = 0;

    frame_path_top DUT (
        .core_clk_ifc    (core_clk_ifc),
        .i_rst_n         (i_rst_n),
        .i_wb_req        (wb_req),
        .o_wb_rsp        (wb_rsp),
        .i_ingress_beat  (ingress_beat),
        .i_ingress_valid (ingress_valid),
        .o_ingress_ready (ingress_ready),
        .o_egress_beat   (egress_beat),
        .o_egress_valid  (egress_valid),
        .i_egress_ready  (egress_ready)
    );

    always #50 core_clk_ifc = ~core_clk_ifc;

    //////////////////////////////////////////////////
    // Random source and reference model

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits   = {bits[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return bits;
    endfunction

    // Queues the expected egress frame, returns 1 when the frame gets cut
    function automatic bit ref_frame();
        frame_pkg::byte_t full_q[$];
        int               lim;
        int               keep;
        if (cfg_hdr_en) begin
            for (int i = 0; i < 6; i++) begin
                full_q.push_back(cfg_dst[47-8*i -: 8]);
            end
            for (int i = 0; i < 6; i++) begin
                full_q.push_back(cfg_src[47-8*i -: 8]);
            end
            full_q.push_back(cfg_etype[15:8]);
            full_q.push_back(cfg_etype[7:0]);
        end
        foreach (payload_q[i]) begin
            full_q.push_back(payload_q[i]);
        end
        lim  = (cfg_max_len == 16'd0) ? 1 : int'(cfg_max_len);
        keep = (full_q.size() < lim) ? full_q.size() : lim;
        for (int i = 0; i < keep; i++) begin
            exp_data_q.push_back(full_q[i]);
            exp_last_q.push_back(i == keep - 1);
        end
        return full_q.size() > lim;
    endfunction

    //////////////////////////////////////////////////
    // Wishbone and stream drivers

    task automatic wb_write(input frame_pkg::wb_addr_t adr, input frame_pkg::wb_data_t dat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        @(posedge core_clk_ifc);
        while (!wb_rsp.ack) begin
            @(posedge core_clk_ifc);
        end
        #10;
        wb_req = '0;
    endtask

    task automatic wb_read(input frame_pkg::wb_addr_t adr, output frame_pkg::wb_data_t dat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        @(posedge core_clk_ifc);
        while (!wb_rsp.ack) begin
            @(posedge core_clk_ifc);
        end
        dat = wb_rsp.dat;
        #10;
        wb_req = '0;
    endtask

    task automatic check_reg(input frame_pkg::wb_addr_t adr, input frame_pkg::wb_data_t exp,
                             input string name);
        frame_pkg::wb_data_t got;
        wb_read(adr, got);
        assert (got == exp) else begin
            $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Writes a register and keeps the model's copy of the config in step
    task automatic write_cfg(input frame_pkg::wb_addr_t adr, input frame_pkg::wb_data_t dat);
        wb_write(adr, dat);
        case (adr)
            frame_pkg::REG_DST_MAC_HI: cfg_dst[47:32] = dat[15:0];
            frame_pkg::REG_DST_MAC_LO: cfg_dst[31:0]  = dat;
            frame_pkg::REG_SRC_MAC_HI: cfg_src[47:32] = dat[15:0];
            frame_pkg::REG_SRC_MAC_LO: cfg_src[31:0]  = dat;
            frame_pkg::REG_ETHERTYPE:  cfg_etype      = dat[15:0];
            frame_pkg::REG_CTRL:       cfg_hdr_en     = dat[0];
            frame_pkg::REG_MAX_LEN:    cfg_max_len    = dat[15:0];
            default: ;
        endcase
    endtask

    task automatic expect_cfg_regs();
        check_reg(frame_pkg::REG_DST_MAC_HI, {16'h0000, cfg_dst[47:32]}, "REG_DST_MAC_HI");
        check_reg(frame_pkg::REG_DST_MAC_LO, cfg_dst[31:0], "REG_DST_MAC_LO");
        check_reg(frame_pkg::REG_SRC_MAC_HI, {16'h0000, cfg_src[47:32]}, "REG_SRC_MAC_HI");
        check_reg(frame_pkg::REG_SRC_MAC_LO, cfg_src[31:0], "REG_SRC_MAC_LO");
        check_reg(frame_pkg::REG_ETHERTYPE, {16'h0000, cfg_etype}, "REG_ETHERTYPE");
        check_reg(frame_pkg::REG_CTRL, {31'h0, cfg_hdr_en}, "REG_CTRL");
        check_reg(frame_pkg::REG_MAX_LEN, {16'h0000, cfg_max_len}, "REG_MAX_LEN");
    endtask

    task automatic send_frame();
        for (int i = 0; i < payload_q.size(); i++) begin
            ingress_beat  = '{data: payload_q[i], last: (i == payload_q.size() - 1)};
            ingress_valid = 1'b1;
            @(posedge core_clk_ifc);
            while (!ingress_ready) begin
                @(posedge core_clk_ifc);
            end
            #10;
        end
        ingress_valid = 1'b0;
    endtask

    // Random lengths from min_len to min_len + span - 1, then wait for the egress to drain
    task automatic run_frames(input int count, input int min_len, input int span);
        int len;
        for (int f = 0; f < count; f++) begin
            len = min_len + int'(rand_bits(7)) % span;
            payload_q.delete();
            for (int i = 0; i < len; i++) begin
                payload_q.push_back(frame_pkg::byte_t'(rand_bits(8)));
            end
            if (ref_frame()) begin
                cut_total++;
            end
            frames_total++;
            send_frame();
        end
        while (exp_data_q.size() != 0) begin
            @(posedge core_clk_ifc);
        end
        repeat (4) @(posedge core_clk_ifc);
        #10;
    endtask

    //////////////////////////////////////////////////
    // Egress ready, comparison and timeout

    always @(posedge core_clk_ifc) begin
        #10;
        if (rand_ready) begin
            egress_ready = ready_lfsr_q[0];
            ready_lfsr_q = lfsr_next(ready_lfsr_q);
        end else begin
            egress_ready = 1'b1;
        end
    end

    always @(posedge core_clk_ifc) begin : egress_compare
        frame_pkg::byte_t exp_data;
        logic             exp_last;
        if (i_rst_n && egress_valid && egress_ready) begin
            if (exp_data_q.size() == 0) begin
                $display("Egress byte 0x%02h at %0d ns came with no byte expected",
                         egress_beat.data, $time);
                other_errors++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_last = exp_last_q.pop_front();
                assert (egress_beat.data == exp_data) else begin
                    $display("** Error at %0d ns: o_egress_beat.data = 0x%02h, expected 0x%02h",
                             $time, egress_beat.data, exp_data);
                    value_errors++;
                end
                assert (egress_beat.last == exp_last) else begin
                    $display("** Error at %0d ns: o_egress_beat.last = %0b, expected %0b",
                             $time, egress_beat.last, exp_last);
                    value_errors++;
                end
            end
        end
    end

    always @(posedge core_clk_ifc) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d egress bytes never seen",
                     cycle_cnt, exp_data_q.size());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        core_clk_ifc  = 1'b0;
        i_rst_n       = 1'b0;
        wb_req        = '0;
        ingress_beat  = '0;
        ingress_valid = 1'b0;
        egress_ready  = 1'b1;
        rand_ready    = 1'b0;
        lfsr_q        = 32'hfe40_4bee;
        ready_lfsr_q  = 32'hfe40_4bee;
        cfg_dst       = frame_pkg::RST_DST_MAC;
        cfg_src       = frame_pkg::RST_SRC_MAC;
        cfg_etype     = frame_pkg::RST_ETHERTYPE;
        cfg_hdr_en    = 1'b0;
        cfg_max_len   = frame_pkg::RST_MAX_LEN;
        repeat (5) @(posedge core_clk_ifc);
        #10;
        i_rst_n = 1'b1;
        @(posedge core_clk_ifc);
        #10;
        assert (!egress_valid && ingress_ready && !wb_rsp.ack) else begin
            $display("Stream valid, ready or ack not at their reset levels after reset");
            other_errors++;
        end

        // Reset values, read back, read-only counters
        expect_cfg_regs();
        check_reg(frame_pkg::REG_FRAME_COUNT, 32'd0, "REG_FRAME_COUNT");
        check_reg(frame_pkg::REG_TRUNC_COUNT, 32'd0, "REG_TRUNC_COUNT");
        check_reg(4'd9, 32'd0, "unmapped word 9");
        write_cfg(frame_pkg::REG_DST_MAC_HI, 32'h0000_02a0);
        write_cfg(frame_pkg::REG_DST_MAC_LO, 32'hc912_3456);
        write_cfg(frame_pkg::REG_SRC_MAC_HI, 32'h0000_02b0);
        write_cfg(frame_pkg::REG_SRC_MAC_LO, 32'hd065_4321);
        write_cfg(frame_pkg::REG_ETHERTYPE, 32'h0000_88b5);
        write_cfg(frame_pkg::REG_CTRL, 32'd1);
        write_cfg(frame_pkg::REG_MAX_LEN, 32'd1234);
        expect_cfg_regs();
        wb_write(frame_pkg::REG_FRAME_COUNT, 32'hdead_beef);
        wb_write(frame_pkg::REG_TRUNC_COUNT, 32'h1234_5678);
        check_reg(frame_pkg::REG_FRAME_COUNT, 32'd0, "REG_FRAME_COUNT");
        check_reg(frame_pkg::REG_TRUNC_COUNT, 32'd0, "REG_TRUNC_COUNT");

        // Plain pass-through, then with the header
        write_cfg(frame_pkg::REG_CTRL, 32'd0);
        write_cfg(frame_pkg::REG_MAX_LEN, 32'd100);
        run_frames(10, 1, 60);
        write_cfg(frame_pkg::REG_CTRL, 32'd1);
        run_frames(10, 1, 60);

        // Truncation to 40 bytes, without and with the header
        write_cfg(frame_pkg::REG_MAX_LEN, 32'd40);
        write_cfg(frame_pkg::REG_CTRL, 32'd0);
        run_frames(8, 20, 71);
        write_cfg(frame_pkg::REG_CTRL, 32'd1);
        run_frames(8, 20, 71);

        // Egress back-pressure
        rand_ready = 1'b1;
        run_frames(6, 1, 90);
        write_cfg(frame_pkg::REG_CTRL, 32'd0);
        run_frames(6, 1, 90);
        rand_ready = 1'b0;

        check_reg(frame_pkg::REG_FRAME_COUNT, frames_total, "REG_FRAME_COUNT");
        check_reg(frame_pkg::REG_TRUNC_COUNT, cut_total, "REG_TRUNC_COUNT");

        $display("Error counts: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
